/* sources.f */
+incdir+include
logic/corePkg.sv
logic/pipeCtrl.sv
logic/instrDecode.sv
logic/regFile.sv
logic/exAlu.sv
logic/exMemStage.sv
logic/coreUnit.sv
tests/core_asserts.sv
tests/tbCore.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tbCore -o simCore \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/simCore > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "No pass message in sim.log"; exit 1; }
exit 0

/* tests/tbCore.sv */
//**************************************************************************
// Core testbench with program ROM, data memory responder and reference model
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module tbCore
	import corePkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int MAX_WAIT = 3;            // Wait cycles come from 2 LFSR bits
	localparam int DRAIN_MARGIN = 20;
	localparam int MAX_STEPS = 1000;
	localparam int MEM_AW = 6;
	localparam int MEM_N = 1 << MEM_AW;

	logic clock;
	logic reset = 1'b1;
	wire [`CORE_PC_W-1:0] imemAddr;
	wire [`CORE_INSTR_W-1:0] imemData;
	wire dataValid;
	wire dataWrite;
	wire [`CORE_DATA_W-1:0] dataAddr;
	wire [`CORE_DATA_W-1:0] dataWData;
	logic dataReady = 1'b0;
	logic [`CORE_DATA_W-1:0] dataRData = '0;
	wire halted;

	logic [`CORE_INSTR_W-1:0] rom [1 << `CORE_PC_W];
	logic [`CORE_DATA_W-1:0] mem [MEM_N];
	logic [`CORE_DATA_W-1:0] refMem [MEM_N];
	logic [`CORE_DATA_W-1:0] expAddr [$];
	logic [`CORE_DATA_W-1:0] expData [$];
	logic [`CORE_DATA_W-1:0] busAddrQ [$];
	logic [`CORE_DATA_W-1:0] busDataQ [$];
	logic [`CORE_DATA_W-1:0] gotAddr;
	logic [`CORE_DATA_W-1:0] gotData;
	logic [15:0] lfsrState = 16'd42687;
	logic [31:0] waitDraw;
	logic reqPending = 1'b0;
	logic reqWrite;
	logic [`CORE_DATA_W-1:0] reqAddr;
	logic [`CORE_DATA_W-1:0] reqData;
	logic [`CORE_PC_W-1:0] refStopPc = '0;
	int waitLeft;
	int progLen = 0;
	int refSteps = 0;
	int storesSeen = 0;
	int budgetCycles = 0;

	coreUnit DUT (
		.clock(clock), .reset(reset),
		.imemAddr(imemAddr), .imemData(imemData),
		.dataValid(dataValid), .dataWrite(dataWrite), .dataAddr(dataAddr),
		.dataWData(dataWData), .dataReady(dataReady), .dataRData(dataRData),
		.halted(halted)
	);

	assign imemData = rom[imemAddr];        // Combinational fetch

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("** Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, expected,
				$time);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic int memIndex(input logic [31:0] addr);
		return int'(addr[MEM_AW-1:0]);
	endfunction

	function automatic logic [15:0] encReg(input coreOpcode op, input int rd, input int rs,
		input int rt);
		return {op, 4'(rd), 4'(rs), 4'(rt)};
	endfunction

	function automatic logic [15:0] encImm(input coreOpcode op, input int rd, input int imm8);
		return {op, 4'(rd), 8'(imm8)};
	endfunction

	task automatic emit(input logic [15:0] word);
		rom[progLen] = word;
		progLen++;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < (1 << `CORE_PC_W); i++)
			rom[i] = '0;
		emit(encImm(opMovi, 1, 5));             // 0
		emit(encImm(opMovi, 2, -3));
		emit(encReg(opAdd, 3, 1, 2));           // Dependent ALU chain
		emit(encReg(opSub, 4, 3, 1));
		emit(encReg(opAnd, 5, 4, 2));
		emit(encReg(opOr, 6, 5, 3));
		emit(encReg(opXor, 7, 6, 4));
		emit(encReg(opAddi, 8, 7, 9));
		emit(encImm(opMovi, 9, 16));            // 8 sets the store base
		emit(encReg(opStore, 3, 9, 0));
		emit(encReg(opStore, 8, 9, 1));
		emit(encReg(opStore, 7, 9, 2));
		emit(encReg(opLoad, 10, 0, 3));         // 12
		emit(encReg(opAdd, 11, 10, 8));         // Load-use
		emit(encReg(opStore, 11, 9, 3));
		emit(encReg(opLoad, 12, 9, 1));
		emit(encReg(opStore, 12, 9, 4));        // 16 has load-use on store data
		emit(encReg(opLoad, 13, 0, 6));
		emit(encReg(opLoad, 14, 0, 9));
		emit(encReg(opXor, 15, 13, 14));
		emit(encReg(opStore, 15, 9, 5));        // 20
		emit(encImm(opMovi, 0, 8'h7F));         // R0 stays zero
		emit(encReg(opAdd, 0, 1, 2));
		emit(encReg(opStore, 0, 9, 6));
		emit(encImm(opMovi, 15, 0));            // 24
		emit(encImm(opBz, 15, 2));              // Taken
		emit(encReg(opStore, 1, 9, 7));         // Flushed slot
		emit(encReg(opStore, 2, 9, 7));         // Flushed slot
		emit(encImm(opBz, 1, 1));               // 28 is not taken
		emit(encReg(opStore, 1, 9, 8));
		emit(encImm(opBra, 0, 2));
		emit(encReg(opStore, 3, 9, 9));
		emit(encReg(opStore, 4, 9, 9));         // 32
		emit(encImm(opMovi, 5, 3));
		emit(encImm(opMovi, 6, -1));
		emit(encReg(opStore, 5, 9, 10));        // 35 is the loop top
		emit(encReg(opAdd, 5, 5, 6));
		emit(encImm(opBz, 5, 1));
		emit(encImm(opBra, 0, -4));             // Back to 35
		emit(encReg(opLoad, 7, 9, 10));         // 39
		emit(encImm(opBz, 7, 1));               // Load-use on branch operand
		emit(encReg(opStore, 7, 9, 11));
		emit(encReg(opHalt, 0, 0, 0));          // 42
		emit(encReg(opStore, 1, 9, 12));        // Never executed
		emit(encReg(opStore, 2, 9, 13));
	endtask

	task automatic fillMemory();
		logic [31:0] word;
		for (int i = 0; i < MEM_N; i++)
		begin
			drawBits(32, word);
			mem[i] = word;
		end
	endtask

	// Instruction-level model of the program
	function automatic void runReference();
		logic [31:0] regs [16];
		logic [`CORE_PC_W-1:0] pc;
		logic [15:0] instr;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [31:0] imm8;
		logic [31:0] imm4;
		logic [31:0] addr;
		logic [31:0] result;
		logic writes;
		logic stopped;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < MEM_N; i++)
			refMem[i] = mem[i];
		pc = '0;
		stopped = 1'b0;
		while (!stopped && (refSteps < MAX_STEPS))
		begin
			instr = rom[pc];
			op = instr[15:12];
			rd = instr[11:8];
			rs = instr[7:4];
			rt = instr[3:0];
			imm8 = {{24{instr[7]}}, instr[7:0]};
			imm4 = {28'b0, instr[3:0]};
			addr = regs[rs] + imm4;
			pc = pc + 1'b1;
			refSteps++;
			writes = op inside {opMovi, opAdd, opSub, opAnd, opOr, opXor, opAddi, opLoad};
			result = '0;
			case (op)
				opMovi:  result = imm8;
				opAdd:   result = regs[rs] + regs[rt];
				opSub:   result = regs[rs] - regs[rt];
				opAnd:   result = regs[rs] & regs[rt];
				opOr:    result = regs[rs] | regs[rt];
				opXor:   result = regs[rs] ^ regs[rt];
				opAddi:  result = addr;
				opLoad:  result = refMem[memIndex(addr)];
				opStore:
				begin
					refMem[memIndex(addr)] = regs[rd];
					expAddr.push_back(addr);
					expData.push_back(regs[rd]);
				end
				opBra:   pc = pc + imm8[`CORE_PC_W-1:0];
				opBz:
					if (regs[rd] == '0)
						pc = pc + imm8[`CORE_PC_W-1:0];
				opHalt:
				begin
					stopped = 1'b1;
					refStopPc = pc + 1'b1;      // Fetch stops two past HALT
				end
				default: ;                      // Nop and unused codes
			endcase
			if (writes && (rd != 4'd0))
				regs[rd] = result;
		end
	endfunction

	// Data memory with 0 to 3 random wait cycles
	always @(negedge clock)
	begin
		if (reset)
		begin
			dataReady = 1'b0;
			reqPending = 1'b0;
		end
		else if (dataReady)
		begin
			if (reqWrite)                       // Transfer took place on the last rising edge
			begin
				mem[memIndex(reqAddr)] = reqData;
				busAddrQ.push_back(reqAddr);
				busDataQ.push_back(reqData);
			end
			dataReady = 1'b0;
			reqPending = 1'b0;
		end
		else if (dataValid)
		begin
			if (!reqPending)
			begin
				reqPending = 1'b1;
				drawBits(2, waitDraw);
				waitLeft = int'(waitDraw[1:0]);
				reqWrite = dataWrite;
				reqAddr = dataAddr;
				reqData = dataWData;
			end
			if (waitLeft == 0)
			begin
				dataReady = 1'b1;
				dataRData = mem[memIndex(reqAddr)];
			end
			else
				waitLeft = waitLeft - 1;
		end
	end

	// Bus writes against the model's store list
	always @(negedge clock)
	begin
		while (busAddrQ.size() > 0)
		begin
			gotAddr = busAddrQ.pop_front();
			gotData = busDataQ.pop_front();
			if (storesSeen >= expAddr.size())
			begin
				$display("Store to address 0x%08h that the reference never made", gotAddr);
				$display("TEST FAILED");
				$fatal(1, "extra store on the data bus");
			end
			checkValue("dataAddr", gotAddr, expAddr[storesSeen]);
			checkValue("dataWData", gotData, expData[storesSeen]);
			storesSeen++;
		end
	end

	always @(negedge clock)
	begin
		if (!reset && (halted === 1'b1))
		begin
			checkValue("dataValid after halt", {31'b0, dataValid}, 32'h0);
			checkValue("imemAddr after halt", 32'(imemAddr), 32'(refStopPc));
		end
	end

	initial
	begin
		wait (budgetCycles > 0);
		repeat (RESET_CYCLES) @(posedge clock);
		repeat (budgetCycles) @(negedge clock);
		$display("Timeout: the core did not halt and drain within %0d cycles", budgetCycles);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		loadProgram();
		fillMemory();
		runReference();
		budgetCycles = refSteps * (MAX_WAIT + 3) + 2 * DRAIN_MARGIN;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (halted !== 1'b1)
			@(negedge clock);
		repeat (DRAIN_MARGIN) @(negedge clock);   // Nothing may move on the bus now
		checkValue("store count", storesSeen, expAddr.size());
		for (int i = 0; i < MEM_N; i++)
			checkValue($sformatf("mem[%0d]", i), mem[i], refMem[i]);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/core_asserts.sv */
//**************************************************************************
// Data bus handshake and halt checks bound into the core top level
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module coreAsserts
(
	input wire                        clock,
	input wire                        reset,
	input wire                        dataValid,
	input wire                        dataReady,
	input wire                        dataWrite,
	input wire [`CORE_DATA_W-1:0]     dataAddr,
	input wire [`CORE_DATA_W-1:0]     dataWData,
	input wire                        halted
);

	// Request frozen until the transfer edge
	property requestHeld;
		@(posedge clock) disable iff (reset)
			(dataValid && !dataReady) |=> (dataValid && $stable(dataWrite) &&
				$stable(dataAddr) && $stable(dataWData));
	endproperty

	requestHeldCheck: assert property (requestHeld)
		else $error("data request changed before dataReady");

	resetClears: assert property (@(posedge clock)
		$fell(reset) |-> (!dataValid && !halted))
		else $error("bus request or halted left set by reset");

	haltedSticky: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted)
		else $error("halted dropped before reset");

	quietAfterHalt: assert property (@(posedge clock) disable iff (reset)
		halted |-> !dataValid)
		else $error("bus request after halt");

endmodule

bind coreUnit coreAsserts handshakeChecks (
	.clock(clock), .reset(reset),
	.dataValid(dataValid), .dataReady(dataReady), .dataWrite(dataWrite),
	.dataAddr(dataAddr), .dataWData(dataWData), .halted(halted)
);

`default_nettype wire

/* logic/coreUnit.sv */
//**************************************************************************
// Core top level: five-stage pipeline wired to fetch and data ports
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module coreUnit
	import corePkg::*;
(
	input  wire                        clock,
	input  wire                        reset,
	output logic [`CORE_PC_W-1:0]      imemAddr,
	input  wire [`CORE_INSTR_W-1:0]    imemData,
	output logic                       dataValid,
	output logic                       dataWrite,
	output logic [`CORE_DATA_W-1:0]    dataAddr,
	output logic [`CORE_DATA_W-1:0]    dataWData,
	input  wire                        dataReady,
	input  wire [`CORE_DATA_W-1:0]     dataRData,
	output logic                       halted
);

	// Stage enables
	wire idAdvance;
	wire idFlush;
	wire exAdvance;
	wire exBubble;
	wire memAdvance;

	// ID outputs
	wire idValid;
	coreOpcode opcode;
	wire [`CORE_RIDX_W-1:0] rd;
	wire [`CORE_RIDX_W-1:0] rsIdx;
	wire [`CORE_RIDX_W-1:0] rtIdx;
	wire useRs;
	wire useRt;
	wire [`CORE_DATA_W-1:0] imm;
	wire [`CORE_PC_W-1:0] idPc;
	wire [`CORE_DATA_W-1:0] rsValue;
	wire [`CORE_DATA_W-1:0] rtValue;

	// EX1 outputs
	wire exValid;
	coreOpcode exOpcode;
	wire [`CORE_RIDX_W-1:0] exRd;
	wire [`CORE_DATA_W-1:0] exResult;
	wire [`CORE_DATA_W-1:0] exStoreData;
	wire [`CORE_RIDX_W-1:0] loadRd;
	wire branchTaken;
	wire [`CORE_PC_W-1:0] branchTarget;
	wire haltSeen;
	wire fwdEn;
	wire [`CORE_RIDX_W-1:0] fwdRd;
	wire [`CORE_DATA_W-1:0] fwdValue;

	// EX2 outputs
	wire memBusy;
	wire haltDone;
	wire wbEn;
	wire [`CORE_RIDX_W-1:0] wbRd;
	wire [`CORE_DATA_W-1:0] wbValue;

	pipeCtrl ctrl (
		.clock(clock), .reset(reset),
		.useRs(useRs), .useRt(useRt), .rsIdx(rsIdx), .rtIdx(rtIdx),
		.loadRd(loadRd), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.haltSeen(haltSeen), .memBusy(memBusy), .haltDone(haltDone),
		.pc(imemAddr), .idAdvance(idAdvance), .idFlush(idFlush),
		.exAdvance(exAdvance), .exBubble(exBubble), .memAdvance(memAdvance),
		.halted(halted)
	);

	instrDecode decode (
		.clock(clock), .reset(reset),
		.idAdvance(idAdvance), .idFlush(idFlush), .pc(imemAddr), .imemData(imemData),
		.idValid(idValid), .opcode(opcode), .rd(rd), .rsIdx(rsIdx), .rtIdx(rtIdx),
		.useRs(useRs), .useRt(useRt), .imm(imm), .idPc(idPc)
	);

	regFile regs (
		.clock(clock), .reset(reset),
		.rsIdx(rsIdx), .rtIdx(rtIdx),
		.fwdEn(fwdEn), .fwdRd(fwdRd), .fwdValue(fwdValue),
		.wbEn(wbEn), .wbRd(wbRd), .wbValue(wbValue),
		.rsValue(rsValue), .rtValue(rtValue)
	);

	exAlu ex1 (
		.clock(clock), .reset(reset),
		.exAdvance(exAdvance), .exBubble(exBubble), .idValid(idValid),
		.opcode(opcode), .rd(rd), .imm(imm), .idPc(idPc),
		.rsValue(rsValue), .rtValue(rtValue),
		.exValid(exValid), .exOpcode(exOpcode), .exRd(exRd), .exResult(exResult),
		.exStoreData(exStoreData), .loadRd(loadRd), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .haltSeen(haltSeen),
		.fwdEn(fwdEn), .fwdRd(fwdRd), .fwdValue(fwdValue)
	);

	exMemStage ex2 (
		.clock(clock), .reset(reset),
		.memAdvance(memAdvance), .exValid(exValid), .exOpcode(exOpcode), .exRd(exRd),
		.exResult(exResult), .exStoreData(exStoreData),
		.dataReady(dataReady), .dataRData(dataRData),
		.dataValid(dataValid), .dataWrite(dataWrite), .dataAddr(dataAddr),
		.dataWData(dataWData), .memBusy(memBusy), .haltDone(haltDone),
		.wbEn(wbEn), .wbRd(wbRd), .wbValue(wbValue)
	);

endmodule

`default_nettype wire

/* logic/exMemStage.sv */
//**************************************************************************
// EX2 stage: data bus requester and writeback select
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module exMemStage
	import corePkg::*;
(
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        memAdvance,
	input  wire                        exValid,
	input  wire coreOpcode             exOpcode,
	input  wire [`CORE_RIDX_W-1:0]     exRd,
	input  wire [`CORE_DATA_W-1:0]     exResult,
	input  wire [`CORE_DATA_W-1:0]     exStoreData,
	input  wire                        dataReady,
	input  wire [`CORE_DATA_W-1:0]     dataRData,
	output logic                       dataValid,
	output logic                       dataWrite,
	output logic [`CORE_DATA_W-1:0]    dataAddr,
	output logic [`CORE_DATA_W-1:0]    dataWData,
	output logic                       memBusy,
	output logic                       haltDone,
	output logic                       wbEn,
	output logic [`CORE_RIDX_W-1:0]    wbRd,
	output logic [`CORE_DATA_W-1:0]    wbValue
);

	logic m2Valid;
	coreOpcode m2Opcode;
	logic [`CORE_RIDX_W-1:0] m2Rd;
	logic [`CORE_DATA_W-1:0] m2Result;
	logic [`CORE_DATA_W-1:0] m2StoreData;
	logic isLoad;
	logic writesReg;

	always_ff @(posedge clock)
	begin
		if (reset)
			m2Valid <= 1'b0;
		else if (memAdvance)
			m2Valid <= exValid;
	end

	// Held while the bus request is pending
	always_ff @(posedge clock)
	begin
		if (memAdvance)
		begin
			m2Opcode <= exOpcode;
			m2Rd <= exRd;
			m2Result <= exResult;
			m2StoreData <= exStoreData;
		end
	end

	always_comb
	begin
		isLoad = (m2Opcode == opLoad);
		writesReg = m2Opcode inside {opMovi, opAdd, opSub, opAnd, opOr, opXor, opAddi, opLoad};
		dataValid = m2Valid && (isLoad || (m2Opcode == opStore));
		dataWrite = m2Valid && (m2Opcode == opStore);
		dataAddr = m2Result;
		dataWData = m2StoreData;
		memBusy = dataValid && !dataReady;      // Low in the transfer cycle
		haltDone = m2Valid && (m2Opcode == opHalt);
		wbEn = m2Valid && writesReg && (m2Rd != '0) && (!isLoad || dataReady);
		wbRd = m2Rd;
		wbValue = isLoad ? dataRData : m2Result;
	end

endmodule

`default_nettype wire

/* logic/exAlu.sv */
//**************************************************************************
// EX1 stage: ALU, address generation and branch resolution
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module exAlu
	import corePkg::*;
(
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        exAdvance,
	input  wire                        exBubble,
	input  wire                        idValid,
	input  wire coreOpcode             opcode,
	input  wire [`CORE_RIDX_W-1:0]     rd,
	input  wire [`CORE_DATA_W-1:0]     imm,
	input  wire [`CORE_PC_W-1:0]       idPc,
	input  wire [`CORE_DATA_W-1:0]     rsValue,
	input  wire [`CORE_DATA_W-1:0]     rtValue,
	output logic                       exValid,
	output coreOpcode                  exOpcode,
	output logic [`CORE_RIDX_W-1:0]    exRd,
	output logic [`CORE_DATA_W-1:0]    exResult,
	output logic [`CORE_DATA_W-1:0]    exStoreData,
	output logic [`CORE_RIDX_W-1:0]    loadRd,
	output logic                       branchTaken,
	output logic [`CORE_PC_W-1:0]      branchTarget,
	output logic                       haltSeen,
	output logic                       fwdEn,
	output logic [`CORE_RIDX_W-1:0]    fwdRd,
	output logic [`CORE_DATA_W-1:0]    fwdValue
);

	logic [`CORE_DATA_W-1:0] exImm;
	logic [`CORE_PC_W-1:0] exPc;
	logic [`CORE_DATA_W-1:0] exRs;
	logic [`CORE_DATA_W-1:0] exRt;     // rt, or rd for opBz and opStore
	logic aluWrites;

	always_ff @(posedge clock)
	begin
		if (reset)
			exValid <= 1'b0;
		else if (exAdvance)
			exValid <= idValid && !exBubble;
	end

	always_ff @(posedge clock)
	begin
		if (exAdvance)
		begin
			exOpcode <= opcode;
			exRd <= rd;
			exImm <= imm;
			exPc <= idPc;
			exRs <= rsValue;
			exRt <= rtValue;
		end
	end

	always_comb
	begin
		case (exOpcode)
			opMovi:                  exResult = exImm;
			opAdd:                   exResult = exRs + exRt;
			opSub:                   exResult = exRs - exRt;
			opAnd:                   exResult = exRs & exRt;
			opOr:                    exResult = exRs | exRt;
			opXor:                   exResult = exRs ^ exRt;
			opAddi, opLoad, opStore: exResult = exRs + exImm;    // Also word address
			default:                 exResult = '0;
		endcase
		exStoreData = exRt;
		aluWrites = exOpcode inside {opMovi, opAdd, opSub, opAnd, opOr, opXor, opAddi};
		loadRd = (exValid && (exOpcode == opLoad)) ? exRd : '0;
		branchTaken = exValid &&
			((exOpcode == opBra) || ((exOpcode == opBz) && (exRt == '0)));
		branchTarget = exPc + 1'b1 + exImm[`CORE_PC_W-1:0];
		haltSeen = exValid && (exOpcode == opHalt);
		fwdEn = exValid && aluWrites;   // Load data not ready yet
		fwdRd = exRd;
		fwdValue = exResult;
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
//**************************************************************************
// Register file, two read ports with EX1 and WB bypass
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module regFile
(
	input  wire                        clock,
	input  wire                        reset,
	input  wire [`CORE_RIDX_W-1:0]     rsIdx,
	input  wire [`CORE_RIDX_W-1:0]     rtIdx,
	input  wire                        fwdEn,
	input  wire [`CORE_RIDX_W-1:0]     fwdRd,
	input  wire [`CORE_DATA_W-1:0]     fwdValue,
	input  wire                        wbEn,
	input  wire [`CORE_RIDX_W-1:0]     wbRd,
	input  wire [`CORE_DATA_W-1:0]     wbValue,
	output logic [`CORE_DATA_W-1:0]    rsValue,
	output logic [`CORE_DATA_W-1:0]    rtValue
);

	logic [`CORE_DATA_W-1:0] regs [`CORE_REG_N];

	// Youngest producer wins
	function automatic logic [`CORE_DATA_W-1:0] readPort(input logic [`CORE_RIDX_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (fwdEn && (fwdRd == idx))
			return fwdValue;
		if (wbEn && (wbRd == idx))
			return wbValue;
		return regs[idx];
	endfunction

	always_comb
	begin
		rsValue = readPort(rsIdx);
		rtValue = readPort(rtIdx);
	end

	always_ff @(posedge clock)
	begin
		if (wbEn && (wbRd != '0) && !reset)
			regs[wbRd] <= wbValue;      // R0 never written
	end

endmodule

`default_nettype wire

/* logic/instrDecode.sv */
//**************************************************************************
// ID stage: instruction register and field decode
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module instrDecode
	import corePkg::*;
(
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        idAdvance,
	input  wire                        idFlush,
	input  wire [`CORE_PC_W-1:0]       pc,
	input  wire [`CORE_INSTR_W-1:0]    imemData,
	output logic                       idValid,
	output coreOpcode                  opcode,
	output logic [`CORE_RIDX_W-1:0]    rd,
	output logic [`CORE_RIDX_W-1:0]    rsIdx,
	output logic [`CORE_RIDX_W-1:0]    rtIdx,
	output logic                       useRs,
	output logic                       useRt,
	output logic [`CORE_DATA_W-1:0]    imm,
	output logic [`CORE_PC_W-1:0]      idPc
);

	logic [`CORE_INSTR_W-1:0] idInstr;
	logic rdIsSource;

	always_ff @(posedge clock)
	begin
		if (reset)
			idValid <= 1'b0;
		else if (idFlush)
			idValid <= 1'b0;            // Younger than a branch or HALT
		else if (idAdvance)
			idValid <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (idAdvance)
		begin
			idInstr <= imemData;
			idPc <= pc;
		end
	end

	always_comb
	begin
		if (idInstr[15:12] <= opHalt)
			opcode = coreOpcode'(idInstr[15:12]);
		else
			opcode = opNop;             // Unassigned codes
		rd = idInstr[11:8];
		rsIdx = idInstr[7:4];
		rdIsSource = (opcode == opBz) || (opcode == opStore);
		rtIdx = rdIsSource ? idInstr[11:8] : idInstr[3:0];
		if (opcode inside {opMovi, opBra, opBz})
			imm = {{(`CORE_DATA_W-8){idInstr[7]}}, idInstr[7:0]};
		else
			imm = {{(`CORE_DATA_W-4){1'b0}}, idInstr[3:0]};
		useRs = idValid &&
			(opcode inside {opAdd, opSub, opAnd, opOr, opXor, opAddi, opLoad, opStore});
		useRt = idValid &&
			(opcode inside {opAdd, opSub, opAnd, opOr, opXor, opStore, opBz});
	end

endmodule

`default_nettype wire

/* logic/pipeCtrl.sv */
//**************************************************************************
// Pipeline control: PC, stage enables, load-use interlock and halt FSM
//**************************************************************************

`include "core_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module pipeCtrl
	import corePkg::*;
(
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      useRs,
	input  wire                      useRt,
	input  wire [`CORE_RIDX_W-1:0]   rsIdx,
	input  wire [`CORE_RIDX_W-1:0]   rtIdx,
	input  wire [`CORE_RIDX_W-1:0]   loadRd,
	input  wire                      branchTaken,
	input  wire [`CORE_PC_W-1:0]     branchTarget,
	input  wire                      haltSeen,
	input  wire                      memBusy,
	input  wire                      haltDone,
	output logic [`CORE_PC_W-1:0]    pc,
	output logic                     idAdvance,
	output logic                     idFlush,
	output logic                     exAdvance,
	output logic                     exBubble,
	output logic                     memAdvance,
	output logic                     halted
);

	ctrlState state;
	ctrlState stateNext;
	logic loadUse;
	logic stopFetch;
	logic pcLoad;

	always_comb
	begin
		loadUse = (loadRd != '0) &&
			((useRs && (rsIdx == loadRd)) || (useRt && (rtIdx == loadRd)));
		stopFetch = haltSeen || (state != stRun);      // HALT in EX1 or draining
		memAdvance = !memBusy;                          // EX2 waits for its transfer
		exAdvance = !memBusy;
		idAdvance = !memBusy && !loadUse;
		// Load-use stall, taken branch and halt all send a bubble into EX1
		exBubble = loadUse || branchTaken || stopFetch;
		idFlush = !memBusy && (branchTaken || stopFetch);
		pcLoad = !loadUse && (branchTaken || !stopFetch);
		halted = (state == stHalted);
	end

	always_comb
	begin
		stateNext = state;
		case (state)
			stRun:
				if (haltSeen)
					stateNext = stDrain;
			stDrain:
				if (haltDone)
					stateNext = stHalted;       // HALT leaves EX2 this edge
			default:
				stateNext = stHalted;           // Stays until reset
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= '0;
			state <= stRun;
		end
		else if (!memBusy)
		begin
			state <= stateNext;
			if (pcLoad)
				pc <= branchTaken ? branchTarget : pc + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/corePkg.sv */
//**************************************************************************
// Core package: opcode and pipeline control state types
//**************************************************************************

`default_nettype none

package corePkg;

	// Opcode field, bits 15..12 of the instruction
	typedef enum logic [3:0]
	{
		opNop   = 4'd0,
		opMovi  = 4'd1,     // rd = sext(imm8)
		opAdd   = 4'd2,
		opSub   = 4'd3,
		opAnd   = 4'd4,
		opOr    = 4'd5,
		opXor   = 4'd6,
		opAddi  = 4'd7,     // rd = rs + zext(imm4)
		opLoad  = 4'd8,     // rd = mem[rs + imm4]
		opStore = 4'd9,     // mem[rs + imm4] = rd
		opBra   = 4'd10,    // pc = pc + 1 + imm8
		opBz    = 4'd11,    // Branch when rd is zero
		opHalt  = 4'd12
	} coreOpcode;

	// Pipeline control FSM
	typedef enum logic [1:0]
	{
		stRun    = 2'd0,
		stDrain  = 2'd1,    // HALT on its way out, fetch stopped
		stHalted = 2'd2
	} ctrlState;

endpackage

`default_nettype wire

/* include/core_cfg.svh */
//**************************************************************************
// Core configuration: widths fixed by the 16-bit instruction format
//**************************************************************************

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_DATA_W     32    // Register and data bus word
`define CORE_PC_W       8     // Word address into instruction memory
`define CORE_REG_N      16    // General registers, R0 reads zero
`define CORE_RIDX_W     4     // Register index field
`define CORE_INSTR_W    16    // Instruction word
`define CORE_DRAIN_N    2     // Edges from HALT in EX1 until halted is high

`endif
